//--- verilog/basic_pkg.sv
package basic_pkg;

    // datapath word
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] XLEN_ZERO = '0;

    // word index taken from wb_adr[4:2]
    localparam logic [2:0] REG_OP1    = 3'd0;
    localparam logic [2:0] REG_OP2    = 3'd1;
    localparam logic [2:0] REG_INSTR  = 3'd2;
    localparam logic [2:0] REG_RESULT = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd4;
    localparam logic [2:0] REG_COUNT  = 3'd5;

    // status word bits
    localparam int STAT_DONE    = 0;
    localparam int STAT_TAKEN   = 1;
    localparam int STAT_ILLEGAL = 2;

endpackage

//--- verilog/stageinfo_pkg.sv
package stageinfo_pkg;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_JALR,
        ALU_COPY1,
        ALU_CZERO_EQ,
        ALU_CZERO_NE,
        ALU_NONE
    } alu_sel;

    // branch compare select
    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE
    } br_sel;

    typedef enum logic {
        OP_SIGNED,
        OP_UNSIGNED
    } sign_sel;

    // rv32 major opcodes handled here
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111
    } rv_opcode;

endpackage

//--- verilog/exe_bus_slave.sv
`timescale 1ns/1ps

module exe_bus_slave (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [4:0]                  wb_adr,
    input  logic [basic_pkg::XLEN-1:0]  wb_dat_w,
    input  logic [3:0]                  wb_sel,
    input  logic [basic_pkg::XLEN-1:0]  result,
    input  logic [2:0]                  status,
    input  logic [15:0]                 count,
    output logic [basic_pkg::XLEN-1:0]  wb_dat_r,
    output logic                        wb_ack,
    output logic [basic_pkg::XLEN-1:0]  op1,
    output logic [basic_pkg::XLEN-1:0]  op2,
    output logic [basic_pkg::XLEN-1:0]  instr,
    output logic                        start
);

    logic [2:0] word_sel;
    logic       req;
    logic [2:0] rd_sel;

    assign word_sel = wb_adr[4:2];
    // new request only outside the ack cycle
    assign req = wb_cyc & wb_stb & ~wb_ack;

    function automatic logic [basic_pkg::XLEN-1:0] byte_merge(
        input logic [basic_pkg::XLEN-1:0] old_val,
        input logic [basic_pkg::XLEN-1:0] new_val,
        input logic [3:0]                 sel
    );
        logic [basic_pkg::XLEN-1:0] merged;
        merged = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
            rd_sel <= basic_pkg::REG_OP1;
            op1    <= basic_pkg::XLEN_ZERO;
            op2    <= basic_pkg::XLEN_ZERO;
            instr  <= basic_pkg::XLEN_ZERO;
        end else begin
            wb_ack <= req;
            start  <= req & wb_we & (word_sel == basic_pkg::REG_INSTR);
            if (req) begin
                rd_sel <= word_sel;
            end
            if (req & wb_we) begin
                case (word_sel)
                    basic_pkg::REG_OP1:   op1 <= byte_merge(op1, wb_dat_w, wb_sel);
                    basic_pkg::REG_OP2:   op2 <= byte_merge(op2, wb_dat_w, wb_sel);
                    basic_pkg::REG_INSTR: instr <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // select latched with the request
    // data follows the registers during the ack cycle so a capture on that edge shows up
    always_comb begin
        case (rd_sel)
            basic_pkg::REG_OP1:    wb_dat_r = op1;
            basic_pkg::REG_OP2:    wb_dat_r = op2;
            basic_pkg::REG_INSTR:  wb_dat_r = instr;
            basic_pkg::REG_RESULT: wb_dat_r = result;
            basic_pkg::REG_STATUS: wb_dat_r = {{(basic_pkg::XLEN-3){1'b0}}, status};
            basic_pkg::REG_COUNT:  wb_dat_r = {{(basic_pkg::XLEN-16){1'b0}}, count};
            default:               wb_dat_r = basic_pkg::XLEN_ZERO;
        endcase
    end

endmodule

//--- verilog/exe_decode.sv
`timescale 1ns/1ps

module exe_decode #(
    parameter bit enable_alu    = 1'b1,
    parameter bit enable_branch = 1'b1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic [basic_pkg::XLEN-1:0]  op1,
    input  logic [basic_pkg::XLEN-1:0]  op2,
    input  logic [basic_pkg::XLEN-1:0]  instr,
    output stageinfo_pkg::alu_sel       alu_fn,
    output stageinfo_pkg::br_sel        br_fn,
    output stageinfo_pkg::sign_sel      sign,
    output logic [basic_pkg::XLEN-1:0]  rs1_val,
    output logic [basic_pkg::XLEN-1:0]  rs2_val,
    output logic                        is_branch,
    output logic                        illegal,
    output logic                        issue
);

    stageinfo_pkg::rv_opcode        opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [basic_pkg::XLEN-1:0]     imm_i;
    stageinfo_pkg::alu_sel          dec_alu;
    stageinfo_pkg::br_sel           dec_br;
    stageinfo_pkg::sign_sel         dec_sign;
    logic                           dec_imm;
    logic                           dec_branch;
    logic                           dec_bad;

    assign opcode = stageinfo_pkg::rv_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{(basic_pkg::XLEN-12){instr[31]}}, instr[31:20]};

    // funct3 map common to OP and OP-IMM
    function automatic stageinfo_pkg::alu_sel base_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return stageinfo_pkg::ALU_ADD;
            3'b001:  return stageinfo_pkg::ALU_SLL;
            3'b010,
            3'b011:  return stageinfo_pkg::ALU_SLT;
            3'b100:  return stageinfo_pkg::ALU_XOR;
            3'b101:  return stageinfo_pkg::ALU_SRL;
            3'b110:  return stageinfo_pkg::ALU_OR;
            default: return stageinfo_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_alu    = stageinfo_pkg::ALU_NONE;
        dec_br     = stageinfo_pkg::BR_NONE;
        dec_sign   = (funct3 == 3'b011) ? stageinfo_pkg::OP_UNSIGNED : stageinfo_pkg::OP_SIGNED;
        dec_imm    = 1'b0;
        dec_branch = 1'b0;
        dec_bad    = 1'b0;
        case (opcode)
            stageinfo_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    dec_alu = base_op(funct3);
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_alu = stageinfo_pkg::ALU_SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    dec_alu = stageinfo_pkg::ALU_SRA;
                end else if (funct7 == 7'b0000111 && funct3 == 3'b101) begin
                    // czero.eqz keeps rs1 only when rs2 is nonzero
                    dec_alu = stageinfo_pkg::ALU_CZERO_NE;
                end else if (funct7 == 7'b0000111 && funct3 == 3'b111) begin
                    dec_alu = stageinfo_pkg::ALU_CZERO_EQ;
                end else begin
                    dec_bad = 1'b1;
                end
            end
            stageinfo_pkg::OPC_OP_IMM: begin
                dec_imm = 1'b1;
                if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
                    dec_alu = stageinfo_pkg::ALU_SRA;
                end else if (funct3[1:0] == 2'b01 && funct7 != 7'b0000000) begin
                    dec_bad = 1'b1;
                end else begin
                    dec_alu = base_op(funct3);
                end
            end
            stageinfo_pkg::OPC_JALR: begin
                dec_imm = 1'b1;
                dec_alu = stageinfo_pkg::ALU_JALR;
                dec_bad = (funct3 != 3'b000);
            end
            stageinfo_pkg::OPC_BRANCH: begin
                dec_branch = 1'b1;
                dec_sign   = funct3[1] ? stageinfo_pkg::OP_UNSIGNED : stageinfo_pkg::OP_SIGNED;
                case (funct3)
                    3'b000:         dec_br = stageinfo_pkg::BR_BEQ;
                    3'b001:         dec_br = stageinfo_pkg::BR_BNE;
                    3'b100, 3'b110: dec_br = stageinfo_pkg::BR_BLT;
                    3'b101, 3'b111: dec_br = stageinfo_pkg::BR_BGE;
                    default:        dec_bad = 1'b1;
                endcase
            end
            default: dec_bad = 1'b1;
        endcase
        // disabled paths refuse their instructions
        if ((dec_branch && !enable_branch) || (!dec_branch && !enable_alu)) begin
            dec_bad = 1'b1;
        end
        if (dec_bad) begin
            dec_alu = stageinfo_pkg::ALU_NONE;
            dec_br  = stageinfo_pkg::BR_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_fn    <= stageinfo_pkg::ALU_NONE;
            br_fn     <= stageinfo_pkg::BR_NONE;
            sign      <= stageinfo_pkg::OP_SIGNED;
            is_branch <= 1'b0;
            illegal   <= 1'b0;
            issue     <= 1'b0;
        end else begin
            issue <= start;
            if (start) begin
                alu_fn    <= dec_alu;
                br_fn     <= dec_br;
                sign      <= dec_sign;
                is_branch <= dec_branch;
                illegal   <= dec_bad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rs1_val <= op1;
            rs2_val <= dec_imm ? imm_i : op2;
        end
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter bit enable_alu    = 1'b1,
    parameter bit enable_branch = 1'b1
) (
    input  stageinfo_pkg::alu_sel       alu_fn,
    input  stageinfo_pkg::br_sel        br_fn,
    input  stageinfo_pkg::sign_sel      sign,
    input  logic [basic_pkg::XLEN-1:0]  rs1_val,
    input  logic [basic_pkg::XLEN-1:0]  rs2_val,
    output logic [basic_pkg::XLEN-1:0]  alu_out,
    output logic                        branch_take
);

    logic                           less;
    logic [basic_pkg::XLEN-1:0]     sum;
    logic [basic_pkg::XLEN-1:0]     alu_res;
    logic                           br_res;

    // one comparator serves slt and the branches
    assign less = (sign == stageinfo_pkg::OP_SIGNED) ?
                  ($signed(rs1_val) < $signed(rs2_val)) :
                  (rs1_val < rs2_val);
    assign sum  = rs1_val + rs2_val;

    always_comb begin
        case (alu_fn)
            stageinfo_pkg::ALU_ADD:      alu_res = sum;
            stageinfo_pkg::ALU_SUB:      alu_res = rs1_val - rs2_val;
            stageinfo_pkg::ALU_AND:      alu_res = rs1_val & rs2_val;
            stageinfo_pkg::ALU_OR:       alu_res = rs1_val | rs2_val;
            stageinfo_pkg::ALU_XOR:      alu_res = rs1_val ^ rs2_val;
            stageinfo_pkg::ALU_SLL:      alu_res = rs1_val << rs2_val[4:0];
            stageinfo_pkg::ALU_SRL:      alu_res = rs1_val >> rs2_val[4:0];
            stageinfo_pkg::ALU_SRA:      alu_res = $unsigned($signed(rs1_val) >>> rs2_val[4:0]);
            stageinfo_pkg::ALU_SLT:      alu_res = {{(basic_pkg::XLEN-1){1'b0}}, less};
            stageinfo_pkg::ALU_JALR:     alu_res = {sum[basic_pkg::XLEN-1:1], 1'b0};
            stageinfo_pkg::ALU_COPY1:    alu_res = rs1_val;
            stageinfo_pkg::ALU_CZERO_EQ: begin
                alu_res = (rs2_val == basic_pkg::XLEN_ZERO) ? rs1_val : basic_pkg::XLEN_ZERO;
            end
            stageinfo_pkg::ALU_CZERO_NE: begin
                alu_res = (rs2_val != basic_pkg::XLEN_ZERO) ? rs1_val : basic_pkg::XLEN_ZERO;
            end
            default:                     alu_res = basic_pkg::XLEN_ZERO;
        endcase
    end

    always_comb begin
        case (br_fn)
            stageinfo_pkg::BR_BEQ: br_res = (rs1_val == rs2_val);
            stageinfo_pkg::BR_BNE: br_res = (rs1_val != rs2_val);
            stageinfo_pkg::BR_BLT: br_res = less;
            stageinfo_pkg::BR_BGE: br_res = !less;
            default:               br_res = 1'b0;
        endcase
    end

    // disabled paths read as zero
    assign alu_out     = enable_alu ? alu_res : basic_pkg::XLEN_ZERO;
    assign branch_take = enable_branch ? br_res : 1'b0;

endmodule

//--- verilog/exe_writeback.sv
`timescale 1ns/1ps

module exe_writeback (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        issue,
    input  logic [basic_pkg::XLEN-1:0]  alu_out,
    input  logic                        branch_take,
    input  logic                        is_branch,
    input  logic                        illegal,
    output logic [basic_pkg::XLEN-1:0]  result,
    output logic [2:0]                  status,
    output logic [15:0]                 count
);

    logic done;
    logic taken;
    logic bad;

    always_ff @(posedge clk) begin
        if (reset) begin
            done   <= 1'b0;
            taken  <= 1'b0;
            bad    <= 1'b0;
            result <= basic_pkg::XLEN_ZERO;
            count  <= 16'd0;
        end else begin
            if (start) begin
                done <= 1'b0;
            end
            // capture wins over a start in the same cycle
            if (issue) begin
                done   <= 1'b1;
                taken  <= is_branch & ~illegal & branch_take;
                bad    <= illegal;
                result <= (is_branch | illegal) ? basic_pkg::XLEN_ZERO : alu_out;
                if (!illegal) begin
                    count <= count + 16'd1;
                end
            end
        end
    end

    assign status[basic_pkg::STAT_DONE]    = done;
    assign status[basic_pkg::STAT_TAKEN]   = taken;
    assign status[basic_pkg::STAT_ILLEGAL] = bad;

endmodule

//--- verilog/exe_unit.sv
`timescale 1ns/1ps

module exe_unit #(
    parameter bit enable_alu    = 1'b1,
    parameter bit enable_branch = 1'b1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [4:0]                  wb_adr,
    input  logic [basic_pkg::XLEN-1:0]  wb_dat_w,
    input  logic [3:0]                  wb_sel,
    output logic [basic_pkg::XLEN-1:0]  wb_dat_r,
    output logic                        wb_ack
);

    logic [basic_pkg::XLEN-1:0]     op1;
    logic [basic_pkg::XLEN-1:0]     op2;
    logic [basic_pkg::XLEN-1:0]     instr;
    logic                           start;
    stageinfo_pkg::alu_sel          alu_fn;
    stageinfo_pkg::br_sel           br_fn;
    stageinfo_pkg::sign_sel         sign;
    logic [basic_pkg::XLEN-1:0]     rs1_val;
    logic [basic_pkg::XLEN-1:0]     rs2_val;
    logic                           is_branch;
    logic                           illegal;
    logic                           issue;
    logic [basic_pkg::XLEN-1:0]     alu_out;
    logic                           branch_take;
    logic [basic_pkg::XLEN-1:0]     result;
    logic [2:0]                     status;
    logic [15:0]                    count;

    exe_bus_slave i_bus (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .result(result),
        .status(status), .count(count), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .op1(op1), .op2(op2), .instr(instr), .start(start)
    );

    exe_decode #(.enable_alu(enable_alu), .enable_branch(enable_branch)) i_decode (
        .clk(clk), .reset(reset), .start(start), .op1(op1), .op2(op2), .instr(instr),
        .alu_fn(alu_fn), .br_fn(br_fn), .sign(sign), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .is_branch(is_branch), .illegal(illegal), .issue(issue)
    );

    alu #(.enable_alu(enable_alu), .enable_branch(enable_branch)) i_alu (
        .alu_fn(alu_fn), .br_fn(br_fn), .sign(sign), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_out(alu_out), .branch_take(branch_take)
    );

    exe_writeback i_wb (
        .clk(clk), .reset(reset), .start(start), .issue(issue), .alu_out(alu_out),
        .branch_take(branch_take), .is_branch(is_branch), .illegal(illegal),
        .result(result), .status(status), .count(count)
    );

endmodule

//--- dv/exe_unit_tb.sv
`timescale 1ns/1ps

module exe_unit_tb;

    localparam int REPS  = 4;
    // 21 alu forms per round, 24 branches, 4 jalr, 4 illegal, one pipelined pair
    localparam int N_OPS = REPS * 21 + 34;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [15:0] lfsr;
    logic [15:0] exp_count;
    int          prot_errors;
    int          data_errors;

    exe_unit i_dut (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    always #10 clk = ~clk;

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            $display("ERROR %0t: request not acknowledged on the next cycle", $time);
            prot_errors++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            $display("ERROR %0t: wb_ack held for more than one cycle", $time);
            prot_errors++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $display("ERROR %0t: wb_ack high without wb_cyc and wb_stb", $time);
            prot_errors++;
        end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected result register, taken and illegal bits for one instruction
    function automatic void model(input logic [31:0] ins, input logic [31:0] a,
                                  input logic [31:0] b, output logic [31:0] res,
                                  output logic tk, output logic bad);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm;
        logic [31:0] y;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        imm = {{20{ins[31]}}, ins[31:20]};
        y   = (opc == 7'h13) ? imm : b;
        res = '0;
        tk  = 1'b0;
        bad = 1'b0;
        if (opc == 7'h33 && f7 == 7'h07 && f3 == 3'b101) begin
            // czero.eqz
            res = (b == 32'd0) ? 32'd0 : a;
        end else if (opc == 7'h33 && f7 == 7'h07 && f3 == 3'b111) begin
            res = (b != 32'd0) ? 32'd0 : a;
        end else if (opc == 7'h33 && f7 == 7'h20 && f3 == 3'b000) begin
            res = a - b;
        end else if ((opc == 7'h33 || opc == 7'h13) && f7 == 7'h20 && f3 == 3'b101) begin
            res = $signed(a) >>> y[4:0];
        end else if ((opc == 7'h33 && f7 != 7'd0) ||
                     (opc == 7'h13 && f3[1:0] == 2'b01 && f7 != 7'd0)) begin
            bad = 1'b1;
        end else if (opc == 7'h33 || opc == 7'h13) begin
            case (f3)
                3'd0:    res = a + y;
                3'd1:    res = a << y[4:0];
                3'd2:    res = {31'd0, $signed(a) < $signed(y)};
                3'd3:    res = {31'd0, a < y};
                3'd4:    res = a ^ y;
                3'd5:    res = a >> y[4:0];
                3'd6:    res = a | y;
                default: res = a & y;
            endcase
        end else if (opc == 7'h67 && f3 == 3'b000) begin
            res = (a + imm) & ~32'd1;
        end else if (opc == 7'h63 && f3[2:1] != 2'b01) begin
            case (f3)
                3'd0:    tk = (a == b);
                3'd1:    tk = (a != b);
                3'd4:    tk = $signed(a) < $signed(b);
                3'd5:    tk = $signed(a) >= $signed(b);
                3'd6:    tk = a < b;
                default: tk = a >= b;
            endcase
        end else begin
            bad = 1'b1;
        end
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s read %h, expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < 8);
        if (!wb_ack) begin
            $display("bus cycle to word %0d got no acknowledge within 8 clocks", wb_adr[4:2]);
            prot_errors++;
        end
    endtask

    task automatic wb_write(input logic [2:0] idx, input logic [31:0] data,
                            input logic [3:0] sel);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = {idx, 2'b00};
        wb_dat_w = data;
        wb_sel   = sel;
        wait_ack();
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] idx, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = {idx, 2'b00};
        wait_ack();
        data = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic run_op(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] exp_res;
        logic [31:0] got;
        logic        exp_tk;
        logic        exp_bad;
        model(ins, a, b, exp_res, exp_tk, exp_bad);
        wb_write(basic_pkg::REG_OP1, a, 4'hf);
        wb_write(basic_pkg::REG_OP2, b, 4'hf);
        wb_write(basic_pkg::REG_INSTR, ins, 4'hf);
        wb_read(basic_pkg::REG_STATUS, got);
        check_word($sformatf("status of %h", ins), got, {29'd0, exp_bad, exp_tk, 1'b1});
        wb_read(basic_pkg::REG_RESULT, got);
        check_word($sformatf("result of %h", ins), got, exp_res);
        if (!exp_bad) begin
            exp_count = exp_count + 16'd1;
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] got;
        logic [31:0] ins;
        logic [31:0] exp_res;
        logic        exp_tk;
        logic        exp_bad;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] bad_ins [4];
        clk         = 1'b0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 5'd0;
        wb_dat_w    = 32'd0;
        wb_sel      = 4'h0;
        lfsr        = 16'd40625;
        exp_count   = 16'd0;
        prot_errors = 0;
        data_errors = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!wb_ack) else begin
            $display("ERROR %0t: wb_ack high after reset", $time);
            prot_errors++;
        end
        for (int r = 0; r < REPS; r++) begin
            // OP, then sub, sra and both czero forms
            for (int k = 0; k < 12; k++) begin
                f7 = (k < 8) ? 7'h00 : ((k < 10) ? 7'h20 : 7'h07);
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : ((k == 11) ? 3'b111 : 3'b101));
                a  = random_bits(32);
                b  = random_bits(32);
                if (k >= 10 && r[0]) begin
                    b = 32'd0;
                end
                run_op({f7, 10'd0, f3, 5'd0, 7'h33}, a, b);
            end
            // OP-IMM, the last pass is srai
            for (int k = 0; k < 9; k++) begin
                f3  = (k == 8) ? 3'b101 : 3'(k);
                imm = random_bits(12);
                if (f3[1:0] == 2'b01) begin
                    imm[11:5] = (k == 8) ? 7'h20 : 7'h00;
                end
                a = random_bits(32);
                b = random_bits(32);
                run_op({imm, 5'd0, f3, 5'd0, 7'h13}, a, b);
            end
        end
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int p = 0; p < 4; p++) begin
                a = random_bits(32);
                b = random_bits(32);
                case (p)
                    0: b = a;
                    1: begin
                        a[31] = 1'b1;
                        b[31] = 1'b0;
                    end
                    2: begin
                        a[31] = 1'b0;
                        b[31] = 1'b1;
                    end
                    default: ;
                endcase
                run_op({7'd0, 10'd0, f3, 5'd0, 7'h63}, a, b);
            end
        end
        // jalr with odd sums
        for (int k = 0; k < 4; k++) begin
            a      = random_bits(32);
            imm    = random_bits(12);
            imm[0] = ~a[0];
            run_op({imm, 5'd0, 3'b000, 5'd0, 7'h67}, a, random_bits(32));
        end
        bad_ins[0] = 32'h0000_2003;
        bad_ins[1] = {7'h01, 10'd0, 3'b000, 5'd0, 7'h33};
        bad_ins[2] = {7'h20, 5'd3, 5'd0, 3'b001, 5'd0, 7'h13};
        bad_ins[3] = {7'h00, 10'd0, 3'b010, 5'd0, 7'h63};
        for (int k = 0; k < 4; k++) begin
            run_op(bad_ins[k], random_bits(32), random_bits(32));
            wb_read(basic_pkg::REG_COUNT, got);
            check_word("count after illegal", got, {16'd0, exp_count});
        end
        a = random_bits(32);
        b = random_bits(32);
        wb_write(basic_pkg::REG_OP1, a, 4'hf);
        wb_write(basic_pkg::REG_OP1, b, 4'b0101);
        // bytes 0 and 2 come from the second write
        a = {a[31:24], b[23:16], a[15:8], b[7:0]};
        wb_read(basic_pkg::REG_OP1, got);
        check_word("op1 after byte write", got, a);
        // two instructions in flight, add then xor
        b   = random_bits(32);
        ins = {7'h00, 10'd0, 3'b100, 5'd0, 7'h33};
        wb_write(basic_pkg::REG_OP2, b, 4'hf);
        wb_write(basic_pkg::REG_INSTR, 32'h0000_0033, 4'hf);
        wb_write(basic_pkg::REG_INSTR, ins, 4'hf);
        wb_read(basic_pkg::REG_STATUS, got);
        check_word("status after pipelined pair", got, 32'd1);
        model(ins, a, b, exp_res, exp_tk, exp_bad);
        wb_read(basic_pkg::REG_RESULT, got);
        check_word("result after pipelined pair", got, exp_res);
        exp_count = exp_count + 16'd2;
        wb_read(basic_pkg::REG_COUNT, got);
        check_word("final count", got, {16'd0, exp_count});
        $display("errors: protocol %0d, data %0d", prot_errors, data_errors);
        if (prot_errors + data_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (N_OPS * 12 + 50) @(posedge clk);
        $display("timeout: tests still running after %0d clock periods", N_OPS * 12 + 50);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- files.f
verilog/basic_pkg.sv
verilog/stageinfo_pkg.sv
verilog/exe_bus_slave.sv
verilog/exe_decode.sv
verilog/alu.sv
verilog/exe_writeback.sv
verilog/exe_unit.sv
dv/exe_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the exe_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exe_unit_tb \
    -f files.f -Mdir obj_dir -o exe_unit_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exe_unit_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
